/* flist.f */
ahb_pkg.sv
dbg_map_pkg.sv
dbg_ahb_interconnect.sv
dbg_rom_table.sv
dbg_cti_regs.sv
mtb_sfr_regs.sv
mtb_sram_ctrl.sv
dbg_ahb_subsys.sv
dbg_ahb_asserts.sv
tb_dbg_ahb_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# Build the debug AHB subsystem testbench with Verilator and run it.
# The exit status is the simulation result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dbg_ahb_subsys --Mdir obj_dir -o sim_tb -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit "$status"
fi

exit 0

/* tb_dbg_ahb_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dbg_ahb_subsys;

   // Direction and response shorthands for the table
   localparam bit   RD  = 1'b0;
   localparam bit   WR  = 1'b1;
   localparam logic OK  = ahb_pkg::HRESP_OKAY;
   localparam logic ERR = ahb_pkg::HRESP_ERROR;

   // Region bases and test addresses
   localparam ahb_pkg::addr_t ROM       = dbg_map_pkg::ROM_TABLE_BASE;
   localparam ahb_pkg::addr_t CTI       = dbg_map_pkg::CTI_BASE;
   localparam ahb_pkg::addr_t SFR       = dbg_map_pkg::MTB_SFR_BASE;
   localparam ahb_pkg::addr_t SRAM_RST  = 32'h2000_0000;
   localparam ahb_pkg::addr_t SRAM_NEW  = 32'h3000_0400;
   localparam ahb_pkg::addr_t UNMAPPED  = 32'hE000_0000;
   localparam int             RND_WORDS = 16;

   // One table row
   typedef struct packed {
      bit                 wr;
      ahb_pkg::addr_t     addr;
      ahb_pkg::data_t     data;      // write data, or expected read data
      logic               resp;
      dbg_map_pkg::trig_t trig;      // trig_in during the address phase
      bit                 chk_trig;
      dbg_map_pkg::trig_t trig_exp;  // trig_out in the data phase
   } xfer_t;

   logic                    hclk;
   logic                    hreset_n;
   logic                    hsel;
   ahb_pkg::addr_t          haddr;
   logic                    htrans_active;
   logic                    hwrite;
   ahb_pkg::data_t          hwdata;
   wire                     hready;
   wire                     hreadyout;
   wire                     hresp;
   wire ahb_pkg::data_t     hrdata;
   dbg_map_pkg::trig_t      trig_in;
   wire dbg_map_pkg::trig_t trig_out;

   xfer_t  xfers[$];
   bit     table_built;
   integer seed;

   // SRAM window base as the table programs it
   ahb_pkg::addr_t sram_base_model;

   // Single master, so the bus ready is the returned ready
   assign hready = hreadyout;

   dbg_ahb_subsys i_dut
   (
      .hclk          (hclk),
      .hreset_n      (hreset_n),
      .hsel          (hsel),
      .haddr         (haddr),
      .htrans_active (htrans_active),
      .hwrite        (hwrite),
      .hwdata        (hwdata),
      .hready        (hready),
      .hreadyout     (hreadyout),
      .hresp         (hresp),
      .hrdata        (hrdata),
      .trig_in       (trig_in),
      .trig_out      (trig_out)
   );

   initial
   begin
      hclk = 1'b0;
      forever #10 hclk = ~hclk;
   end

   task automatic report_fail(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
   endtask

   task automatic add_xfer(input bit wr, input ahb_pkg::addr_t addr,
                           input ahb_pkg::data_t data, input logic resp,
                           input dbg_map_pkg::trig_t trig, input bit chk_trig,
                           input dbg_map_pkg::trig_t trig_exp);
      xfer_t x;
      x = '{wr, addr, data, resp, trig, chk_trig, trig_exp};
      xfers.push_back(x);
   endtask

   // True when the address falls in the 1 KB SRAM window
   function automatic bit in_sram_window(input ahb_pkg::addr_t addr);
      return addr[31:dbg_map_pkg::SRAM_AWIDTH] ==
             sram_base_model[31:dbg_map_pkg::SRAM_AWIDTH];
   endfunction

   // ------------------------------------------------------------
   // Transfer table
   // ------------------------------------------------------------
   task automatic build_table();
      int                     k;
      dbg_map_pkg::sram_idx_t idx;
      ahb_pkg::data_t         wdat;
      dbg_map_pkg::sram_idx_t rnd_idx [0:RND_WORDS-1];
      ahb_pkg::data_t         model [0:255];
      // ROM table entries, then a refused write that leaves entry 0 unchanged
      add_xfer(RD, ROM + dbg_map_pkg::ROM_ENTRY0_OFS, 32'h0000_1003, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, ROM + dbg_map_pkg::ROM_ENTRY1_OFS, 32'h0000_2003, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, ROM + 32'h008, 32'h0000_0000, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, ROM + dbg_map_pkg::ROM_MEMTYPE_OFS, 32'h0000_0001, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(WR, ROM + dbg_map_pkg::ROM_ENTRY0_OFS, 32'hDEAD_BEEF, ERR, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, ROM + dbg_map_pkg::ROM_ENTRY0_OFS, 32'h0000_1003, OK, 4'h0, 1'b0, 4'h0);
      // CTI enable, software set and clear
      add_xfer(WR, CTI + dbg_map_pkg::CTI_CONTROL_OFS, 32'h0000_0001, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(WR, CTI + dbg_map_pkg::CTI_APPSET_OFS, 32'h0000_0005, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, CTI + dbg_map_pkg::CTI_TRIGOUT_OFS, 32'h0000_0005, OK, 4'h0, 1'b1, 4'h5);
      add_xfer(WR, CTI + dbg_map_pkg::CTI_APPCLEAR_OFS, 32'h0000_0001, OK, 4'h0, 1'b0, 4'h0);
      // Input 8 pulsed here lands in the latch two edges later
      add_xfer(RD, CTI + dbg_map_pkg::CTI_TRIGOUT_OFS, 32'h0000_0004, OK, 4'h8, 1'b1, 4'h4);
      add_xfer(RD, CTI + dbg_map_pkg::CTI_TRIGOUT_OFS, 32'h0000_000C, OK, 4'h0, 1'b1, 4'hC);
      // Disabled CTI drops its outputs and keeps the latch readable
      add_xfer(WR, CTI + dbg_map_pkg::CTI_CONTROL_OFS, 32'h0000_0000, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, CTI + dbg_map_pkg::CTI_TRIGOUT_OFS, 32'h0000_000C, OK, 4'h0, 1'b1, 4'h0);
      // SRAM locked after reset, then opened through MASTER bit 31
      add_xfer(WR, SRAM_RST, 32'h1234_5678, ERR, 4'h0, 1'b0, 4'h0);
      add_xfer(WR, SFR + dbg_map_pkg::MTB_MASTER_OFS, 32'h8000_0000, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, SFR + dbg_map_pkg::MTB_MASTER_OFS, 32'h8000_0000, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(WR, SRAM_RST, 32'h1234_5678, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, SRAM_RST, 32'h1234_5678, OK, 4'h0, 1'b0, 4'h0);
      // Relocating the window leaves the old base unmapped
      add_xfer(WR, SFR + dbg_map_pkg::MTB_BASE_OFS, SRAM_NEW, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, SFR + dbg_map_pkg::MTB_BASE_OFS, SRAM_NEW, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, SRAM_NEW, 32'h1234_5678, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, SRAM_RST, 32'h0000_0000, OK, 4'h0, 1'b0, 4'h0);
      // Nothing decoded
      add_xfer(RD, UNMAPPED, 32'h0000_0000, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(WR, UNMAPPED, 32'hA5A5_A5A5, OK, 4'h0, 1'b0, 4'h0);
      add_xfer(RD, UNMAPPED, 32'h0000_0000, OK, 4'h0, 1'b0, 4'h0);

      // ------------------------------------------------------------
      // Random SRAM words are read back in reverse order
      // ------------------------------------------------------------
      for (k = 0; k < RND_WORDS; k++)
      begin
         idx        = dbg_map_pkg::sram_idx_t'($random(seed));
         wdat       = $random(seed);
         rnd_idx[k] = idx;
         model[idx] = wdat;
         add_xfer(WR, SRAM_NEW | {22'd0, idx, 2'b00}, wdat, OK, 4'h0, 1'b0, 4'h0);
      end
      // Repeated indices expect the last value written
      for (k = RND_WORDS - 1; k >= 0; k--)
         add_xfer(RD, SRAM_NEW | {22'd0, rnd_idx[k], 2'b00}, model[rnd_idx[k]], OK,
                  4'h0, 1'b0, 4'h0);
   endtask

   // Compares the data phase of one row while it completes
   task automatic check_response(input int k, input int stalls);
      xfer_t x;
      int    stalls_exp;
      x = xfers[k];
      // SRAM reads wait once, and an ERROR holds the bus for its first cycle
      stalls_exp = (x.resp == ERR || (!x.wr && in_sram_window(x.addr))) ? 1 : 0;
      assert (stalls == stalls_exp)
         else report_fail($sformatf("row %0d addr %h: %0d wait states, expected %0d",
                                    k, x.addr, stalls, stalls_exp));
      assert (hresp === x.resp)
         else report_fail($sformatf("row %0d addr %h: hresp %b, expected %b",
                                    k, x.addr, hresp, x.resp));
      if (!x.wr && x.resp == OK)
      begin
         assert (hrdata === x.data)
            else report_fail($sformatf("row %0d addr %h: hrdata %h, expected %h",
                                       k, x.addr, hrdata, x.data));
      end
      if (x.chk_trig)
      begin
         assert (trig_out === x.trig_exp)
            else report_fail($sformatf("row %0d: trig_out %h, expected %h",
                                       k, trig_out, x.trig_exp));
      end
      // A BASE write moves the window for later rows
      if (x.wr && x.addr == SFR + dbg_map_pkg::MTB_BASE_OFS)
         sram_base_model = x.data;
   endtask

   // ------------------------------------------------------------
   // Pipelined master
   // ------------------------------------------------------------
   task automatic run_table();
      int i;
      int n;
      int stalls;
      n = xfers.size();
      @(posedge hclk);
      for (i = 0; i <= n; i++)
      begin
         // Address phase of row i, or an idle bus after the last row
         if (i < n)
         begin
            hsel          <= 1'b1;
            htrans_active <= 1'b1;
            hwrite        <= xfers[i].wr;
            haddr         <= xfers[i].addr;
            trig_in       <= xfers[i].trig;
         end
         else
         begin
            hsel          <= 1'b0;
            htrans_active <= 1'b0;
            hwrite        <= 1'b0;
            haddr         <= '0;
            trig_in       <= '0;
         end
         // Row i-1 was accepted on this edge and its write data follows
         if (i > 0)
            hwdata <= xfers[i-1].wr ? xfers[i-1].data : '0;
         // Responses are settled at the falling edge
         stalls = 0;
         @(negedge hclk);
         while (!hreadyout)
         begin
            stalls++;
            @(negedge hclk);
         end
         if (i > 0)
            check_response(i - 1, stalls);
         @(posedge hclk);
      end
   endtask

   initial
   begin
      $timeformat(-9, 0, " ns", 0);
      seed            = 32'h4a32800d;
      sram_base_model = SRAM_RST;
      hreset_n        = 1'b0;
      hsel            = 1'b0;
      haddr           = '0;
      htrans_active   = 1'b0;
      hwrite          = 1'b0;
      hwdata          = '0;
      trig_in         = '0;
      build_table();
      table_built = 1'b1;
      repeat (4) @(posedge hclk);
      hreset_n <= 1'b1;
      run_table();
      $display("TEST PASSED");
      $finish;
   end

   // Watchdog budget grows with the table
   initial
   begin
      wait (table_built);
      repeat (xfers.size() * 4 + 200) @(posedge hclk);
      $display("Timeout: the bus did not finish %0d transfers in time", xfers.size());
      $display("TEST FAILED");
      $fatal(1, "Watchdog expired");
   end

endmodule

`default_nettype wire

/* dbg_ahb_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_ahb_asserts
(
   input wire hclk,
   input wire hreset_n,
   input wire hsel_rom,
   input wire hsel_cti,
   input wire hsel_mtb_sfr,
   input wire hsel_mtb_sram,
   input wire hreadyout,
   input wire hresp
);

   // Decoder never hits two regions at once
   a_one_select : assert property (@(posedge hclk) disable iff (!hreset_n)
      $onehot0({hsel_rom, hsel_cti, hsel_mtb_sfr, hsel_mtb_sram}))
      else $error("More than one slave select in an address phase");

   // Nothing selected coming out of reset
   a_ready_after_reset : assert property (@(posedge hclk)
      $rose(hreset_n) |-> hreadyout)
      else $error("hreadyout low after reset");

   // Two-cycle ERROR response
   a_error_second_cycle : assert property (@(posedge hclk) disable iff (!hreset_n)
      (hresp && !hreadyout) |=> (hresp && hreadyout))
      else $error("ERROR response not completed in its second cycle");

   // At most two stall cycles in a row
   a_stall_limit : assert property (@(posedge hclk) disable iff (!hreset_n)
      (!$past(hreadyout, 2) && !$past(hreadyout)) |-> hreadyout)
      else $error("hreadyout low for more than two cycles");

endmodule

bind dbg_ahb_subsys dbg_ahb_asserts i_ahb_asserts
(
   .hclk          (hclk),
   .hreset_n      (hreset_n),
   .hsel_rom      (hsel_rom),
   .hsel_cti      (hsel_cti),
   .hsel_mtb_sfr  (hsel_mtb_sfr),
   .hsel_mtb_sram (hsel_mtb_sram),
   .hreadyout     (hreadyout),
   .hresp         (hresp)
);

`default_nettype wire

/* dbg_ahb_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_ahb_subsys
(
   input  wire                     hclk,
   input  wire                     hreset_n,
   input  wire                     hsel,
   input  wire ahb_pkg::addr_t     haddr,
   input  wire                     htrans_active,
   input  wire                     hwrite,
   input  wire ahb_pkg::data_t     hwdata,
   input  wire                     hready,
   output wire                     hreadyout,
   output wire                     hresp,
   output wire ahb_pkg::data_t     hrdata,
   input  wire dbg_map_pkg::trig_t trig_in,
   output wire dbg_map_pkg::trig_t trig_out
);

   // Decoded selects
   wire hsel_rom;
   wire hsel_cti;
   wire hsel_mtb_sfr;
   wire hsel_mtb_sram;

   // Per-slave responses
   wire                 hreadyout_rom;
   wire                 hresp_rom;
   wire ahb_pkg::data_t hrdata_rom;
   wire                 hreadyout_cti;
   wire                 hresp_cti;
   wire ahb_pkg::data_t hrdata_cti;
   wire                 hreadyout_sfr;
   wire                 hresp_sfr;
   wire ahb_pkg::data_t hrdata_sfr;
   wire                 hreadyout_sram;
   wire                 hresp_sram;
   wire ahb_pkg::data_t hrdata_sram;

   // Shared MTB path
   wire                 hreadyout_mtb;
   wire                 hresp_mtb;
   wire ahb_pkg::data_t hrdata_mtb;

   // MTB configuration
   wire ahb_pkg::addr_t sram_base;
   wire                 sram_wr_en;

   // ------------------------------------------------------------
   // MTB response merge
   // ------------------------------------------------------------
   // Each slave idles at ready, OKAY, zero outside its own data phase
   assign hreadyout_mtb = hreadyout_sfr & hreadyout_sram;
   assign hresp_mtb     = hresp_sfr | hresp_sram;
   assign hrdata_mtb    = hrdata_sfr | hrdata_sram;

   dbg_ahb_interconnect i_interconnect
   (
      .hclk          (hclk),
      .hreset_n      (hreset_n),
      .hsel          (hsel),
      .hready        (hready),
      .haddr         (haddr),
      .sram_base     (sram_base),
      .hreadyout_rom (hreadyout_rom),
      .hresp_rom     (hresp_rom),
      .hrdata_rom    (hrdata_rom),
      .hreadyout_cti (hreadyout_cti),
      .hresp_cti     (hresp_cti),
      .hrdata_cti    (hrdata_cti),
      .hreadyout_mtb (hreadyout_mtb),
      .hresp_mtb     (hresp_mtb),
      .hrdata_mtb    (hrdata_mtb),
      .hsel_rom      (hsel_rom),
      .hsel_cti      (hsel_cti),
      .hsel_mtb_sfr  (hsel_mtb_sfr),
      .hsel_mtb_sram (hsel_mtb_sram),
      .hreadyout     (hreadyout),
      .hresp         (hresp),
      .hrdata        (hrdata)
   );

   dbg_rom_table i_rom_table
   (
      .hclk          (hclk),
      .hreset_n      (hreset_n),
      .hsel          (hsel_rom),
      .haddr         (haddr),
      .htrans_active (htrans_active),
      .hwrite        (hwrite),
      .hready        (hready),
      .hreadyout     (hreadyout_rom),
      .hresp         (hresp_rom),
      .hrdata        (hrdata_rom)
   );

   dbg_cti_regs i_cti_regs
   (
      .hclk          (hclk),
      .hreset_n      (hreset_n),
      .hsel          (hsel_cti),
      .haddr         (haddr),
      .htrans_active (htrans_active),
      .hwrite        (hwrite),
      .hwdata        (hwdata),
      .hready        (hready),
      .trig_in       (trig_in),
      .hreadyout     (hreadyout_cti),
      .hresp         (hresp_cti),
      .hrdata        (hrdata_cti),
      .trig_out      (trig_out)
   );

   mtb_sfr_regs i_mtb_sfr_regs
   (
      .hclk          (hclk),
      .hreset_n      (hreset_n),
      .hsel          (hsel_mtb_sfr),
      .haddr         (haddr),
      .htrans_active (htrans_active),
      .hwrite        (hwrite),
      .hwdata        (hwdata),
      .hready        (hready),
      .hreadyout     (hreadyout_sfr),
      .hresp         (hresp_sfr),
      .hrdata        (hrdata_sfr),
      .sram_base     (sram_base),
      .sram_wr_en    (sram_wr_en)
   );

   mtb_sram_ctrl i_mtb_sram_ctrl
   (
      .hclk          (hclk),
      .hreset_n      (hreset_n),
      .hsel          (hsel_mtb_sram),
      .haddr         (haddr),
      .htrans_active (htrans_active),
      .hwrite        (hwrite),
      .hwdata        (hwdata),
      .hready        (hready),
      .sram_wr_en    (sram_wr_en),
      .hreadyout     (hreadyout_sram),
      .hresp         (hresp_sram),
      .hrdata        (hrdata_sram)
   );

endmodule

`default_nettype wire

/* mtb_sram_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module mtb_sram_ctrl
(
   input  wire                 hclk,
   input  wire                 hreset_n,
   input  wire                 hsel,
   input  wire ahb_pkg::addr_t haddr,
   input  wire                 htrans_active,
   input  wire                 hwrite,
   input  wire ahb_pkg::data_t hwdata,
   input  wire                 hready,
   input  wire                 sram_wr_en,
   output logic                hreadyout,
   output logic                hresp,
   output ahb_pkg::data_t      hrdata
);

   ahb_pkg::resp_state_t state;
   ahb_pkg::resp_state_t state_nxt;

   logic xfer;
   logic wr_q;
   logic rd_vld;

   dbg_map_pkg::sram_idx_t idx_q;
   ahb_pkg::data_t         rdata_q;

   // 1 KB trace buffer
   ahb_pkg::data_t mem [0:(1 << (dbg_map_pkg::SRAM_AWIDTH-2))-1];

   assign xfer = hsel & htrans_active & hready;

   // ------------------------------------------------------------
   // Response FSM
   // ------------------------------------------------------------
   always_comb
   begin
      state_nxt = ahb_pkg::RESP_IDLE;
      case (state)
         ahb_pkg::RESP_WAIT: state_nxt = ahb_pkg::RESP_IDLE;
         ahb_pkg::RESP_ERR1: state_nxt = ahb_pkg::RESP_ERR2;
         default:
         begin
            // Reads stall once, locked writes fail
            if (xfer && !hwrite)
               state_nxt = ahb_pkg::RESP_WAIT;
            else if (xfer && !sram_wr_en)
               state_nxt = ahb_pkg::RESP_ERR1;
         end
      endcase
   end

   always_ff @(posedge hclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         state  <= ahb_pkg::RESP_IDLE;
         wr_q   <= 1'b0;
         rd_vld <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (hready)
            wr_q <= xfer & hwrite & sram_wr_en;
         // Read data shown for the cycle after the stall
         if (state == ahb_pkg::RESP_WAIT)
            rd_vld <= 1'b1;
         else if (hready)
            rd_vld <= 1'b0;
      end
   end

   // Array, index and read register
   always_ff @(posedge hclk)
   begin
      if (xfer)
         idx_q <= haddr[dbg_map_pkg::SRAM_AWIDTH-1:2];
      if (wr_q)
         mem[idx_q] <= hwdata;
      if (state == ahb_pkg::RESP_WAIT)
         rdata_q <= mem[idx_q];
   end

   assign hreadyout = !(state == ahb_pkg::RESP_WAIT || state == ahb_pkg::RESP_ERR1);
   assign hresp     = (state == ahb_pkg::RESP_ERR1 || state == ahb_pkg::RESP_ERR2) ?
                      ahb_pkg::HRESP_ERROR : ahb_pkg::HRESP_OKAY;
   assign hrdata    = rd_vld ? rdata_q : '0;

endmodule

`default_nettype wire

/* mtb_sfr_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module mtb_sfr_regs
(
   input  wire                 hclk,
   input  wire                 hreset_n,
   input  wire                 hsel,
   input  wire ahb_pkg::addr_t haddr,
   input  wire                 htrans_active,
   input  wire                 hwrite,
   input  wire ahb_pkg::data_t hwdata,
   input  wire                 hready,
   output logic                hreadyout,
   output logic                hresp,
   output ahb_pkg::data_t      hrdata,
   output ahb_pkg::addr_t      sram_base,
   output logic                sram_wr_en
);

   logic xfer;
   logic wr_q;
   logic rd_q;
   logic [dbg_map_pkg::REGION_LSB-1:0] ofs_q;

   // Stored part of BASE, window-aligned
   logic [ahb_pkg::ADDR_W-1:dbg_map_pkg::SRAM_AWIDTH] base_hi;

   assign xfer = hsel & htrans_active & hready;

   always_ff @(posedge hclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end
      else if (hready)
      begin
         wr_q <= xfer & hwrite;
         rd_q <= xfer & ~hwrite;
      end
   end

   always_ff @(posedge hclk)
   begin
      if (xfer)
         ofs_q <= haddr[dbg_map_pkg::REGION_LSB-1:0];
   end

   // ------------------------------------------------------------
   // MASTER and BASE
   // ------------------------------------------------------------
   always_ff @(posedge hclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         sram_wr_en <= 1'b0;
         base_hi    <= dbg_map_pkg::SRAM_BASE_RESET[ahb_pkg::ADDR_W-1:dbg_map_pkg::SRAM_AWIDTH];
      end
      else if (wr_q)
      begin
         // MASTER bit 31 opens the SRAM to bus writes
         if (ofs_q == dbg_map_pkg::MTB_MASTER_OFS)
            sram_wr_en <= hwdata[31];
         if (ofs_q == dbg_map_pkg::MTB_BASE_OFS)
            base_hi <= hwdata[ahb_pkg::ADDR_W-1:dbg_map_pkg::SRAM_AWIDTH];
      end
   end

   // Low bits always zero
   assign sram_base = {base_hi, {dbg_map_pkg::SRAM_AWIDTH{1'b0}}};

   assign hreadyout = 1'b1;
   assign hresp     = ahb_pkg::HRESP_OKAY;

   // Readback, zero outside a read data phase
   always_comb
   begin
      hrdata = '0;
      if (rd_q && ofs_q == dbg_map_pkg::MTB_MASTER_OFS)
         hrdata = {sram_wr_en, {(ahb_pkg::DATA_W-1){1'b0}}};
      else if (rd_q && ofs_q == dbg_map_pkg::MTB_BASE_OFS)
         hrdata = sram_base;
   end

endmodule

`default_nettype wire

/* dbg_cti_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_cti_regs
(
   input  wire                     hclk,
   input  wire                     hreset_n,
   input  wire                     hsel,
   input  wire ahb_pkg::addr_t     haddr,
   input  wire                     htrans_active,
   input  wire                     hwrite,
   input  wire ahb_pkg::data_t     hwdata,
   input  wire                     hready,
   input  wire dbg_map_pkg::trig_t trig_in,
   output logic                    hreadyout,
   output logic                    hresp,
   output ahb_pkg::data_t          hrdata,
   output dbg_map_pkg::trig_t      trig_out
);

   logic xfer;
   logic wr_q;
   logic rd_q;
   logic [dbg_map_pkg::REGION_LSB-1:0] ofs_q;

   // CONTROL bit 0
   logic cti_en;

   dbg_map_pkg::trig_t trig_q;
   dbg_map_pkg::trig_t trig_latch;
   dbg_map_pkg::trig_t app_set;
   dbg_map_pkg::trig_t app_clr;

   assign xfer = hsel & htrans_active & hready;

   // ------------------------------------------------------------
   // Address phase capture
   // ------------------------------------------------------------
   always_ff @(posedge hclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end
      else if (hready)
      begin
         wr_q <= xfer & hwrite;
         rd_q <= xfer & ~hwrite;
      end
   end

   always_ff @(posedge hclk)
   begin
      if (xfer)
         ofs_q <= haddr[dbg_map_pkg::REGION_LSB-1:0];
   end

   // Application set and clear pulses, data phase
   always_comb
   begin
      app_set = '0;
      app_clr = '0;
      if (wr_q && ofs_q == dbg_map_pkg::CTI_APPSET_OFS)
         app_set = hwdata[dbg_map_pkg::TRIG_W-1:0];
      if (wr_q && ofs_q == dbg_map_pkg::CTI_APPCLEAR_OFS)
         app_clr = hwdata[dbg_map_pkg::TRIG_W-1:0];
   end

   // ------------------------------------------------------------
   // Control and trigger latch
   // ------------------------------------------------------------
   always_ff @(posedge hclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         cti_en     <= 1'b0;
         trig_q     <= '0;
         trig_latch <= '0;
      end
      else
      begin
         if (wr_q && ofs_q == dbg_map_pkg::CTI_CONTROL_OFS)
            cti_en <= hwdata[0];
         // Inputs sampled first, latched on the following edge
         trig_q <= trig_in;
         // Clear acts on the old latch, new events still land
         trig_latch <= (trig_latch & ~app_clr) | app_set |
                       (trig_q & {dbg_map_pkg::TRIG_W{cti_en}});
      end
   end

   // Outputs drop when disabled, latch itself is kept
   assign trig_out = trig_latch & {dbg_map_pkg::TRIG_W{cti_en}};

   // Zero wait state, never errors
   assign hreadyout = 1'b1;
   assign hresp     = ahb_pkg::HRESP_OKAY;

   // Only TRIGOUT is readable
   assign hrdata = (rd_q && ofs_q == dbg_map_pkg::CTI_TRIGOUT_OFS) ?
                   ahb_pkg::data_t'(trig_latch) : '0;

endmodule

`default_nettype wire

/* dbg_rom_table.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_rom_table
(
   input  wire                 hclk,
   input  wire                 hreset_n,
   input  wire                 hsel,
   input  wire ahb_pkg::addr_t haddr,
   input  wire                 htrans_active,
   input  wire                 hwrite,
   input  wire                 hready,
   output logic                hreadyout,
   output logic                hresp,
   output ahb_pkg::data_t      hrdata
);

   ahb_pkg::resp_state_t state;
   ahb_pkg::resp_state_t state_nxt;

   logic xfer_rd;
   logic xfer_wr;
   logic rd_q;
   logic [dbg_map_pkg::REGION_LSB-1:0] ofs_q;

   // Accepted address phases
   assign xfer_rd = hsel & htrans_active & hready & ~hwrite;
   assign xfer_wr = hsel & htrans_active & hready & hwrite;

   // Writes are refused, two-cycle ERROR
   always_comb
   begin
      if (state == ahb_pkg::RESP_ERR1)
         state_nxt = ahb_pkg::RESP_ERR2;
      else if (xfer_wr)
         state_nxt = ahb_pkg::RESP_ERR1;
      else
         state_nxt = ahb_pkg::RESP_IDLE;
   end

   always_ff @(posedge hclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         state <= ahb_pkg::RESP_IDLE;
         rd_q  <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (hready)
            rd_q <= xfer_rd;
      end
   end

   // Offset of the read in flight
   always_ff @(posedge hclk)
   begin
      if (xfer_rd)
         ofs_q <= haddr[dbg_map_pkg::REGION_LSB-1:0];
   end

   assign hreadyout = (state != ahb_pkg::RESP_ERR1);
   assign hresp     = (state == ahb_pkg::RESP_ERR1 || state == ahb_pkg::RESP_ERR2) ?
                      ahb_pkg::HRESP_ERROR : ahb_pkg::HRESP_OKAY;

   // Constant table, holes read zero
   always_comb
   begin
      hrdata = '0;
      if (rd_q)
      begin
         case (ofs_q)
            dbg_map_pkg::ROM_ENTRY0_OFS:  hrdata = dbg_map_pkg::ROM_ENTRY0;
            dbg_map_pkg::ROM_ENTRY1_OFS:  hrdata = dbg_map_pkg::ROM_ENTRY1;
            // System memory present
            dbg_map_pkg::ROM_MEMTYPE_OFS: hrdata = ahb_pkg::data_t'(1);
            default:                      hrdata = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* dbg_ahb_interconnect.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_ahb_interconnect
(
   input  wire                 hclk,
   input  wire                 hreset_n,
   input  wire                 hsel,
   input  wire                 hready,
   input  wire ahb_pkg::addr_t haddr,
   input  wire ahb_pkg::addr_t sram_base,
   input  wire                 hreadyout_rom,
   input  wire                 hresp_rom,
   input  wire ahb_pkg::data_t hrdata_rom,
   input  wire                 hreadyout_cti,
   input  wire                 hresp_cti,
   input  wire ahb_pkg::data_t hrdata_cti,
   input  wire                 hreadyout_mtb,
   input  wire                 hresp_mtb,
   input  wire ahb_pkg::data_t hrdata_mtb,
   output logic                hsel_rom,
   output logic                hsel_cti,
   output logic                hsel_mtb_sfr,
   output logic                hsel_mtb_sram,
   output logic                hreadyout,
   output logic                hresp,
   output ahb_pkg::data_t      hrdata
);

   // Raw region hits, address phase
   logic hit_rom;
   logic hit_cti;
   logic hit_sfr;
   logic hit_sram;

   // Data-phase selects, one per response path
   logic sel_rom_q;
   logic sel_cti_q;
   logic sel_mtb_q;
   logic sel_none;

   // ------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------
   assign hit_rom = haddr[31:dbg_map_pkg::REGION_LSB] ==
                    dbg_map_pkg::ROM_TABLE_BASE[31:dbg_map_pkg::REGION_LSB];
   assign hit_cti = haddr[31:dbg_map_pkg::REGION_LSB] ==
                    dbg_map_pkg::CTI_BASE[31:dbg_map_pkg::REGION_LSB];
   assign hit_sfr = haddr[31:dbg_map_pkg::REGION_LSB] ==
                    dbg_map_pkg::MTB_SFR_BASE[31:dbg_map_pkg::REGION_LSB];
   // SRAM window follows the programmed base
   assign hit_sram = haddr[31:dbg_map_pkg::SRAM_AWIDTH] ==
                     sram_base[31:dbg_map_pkg::SRAM_AWIDTH];

   always_comb
   begin
      hsel_rom      = hsel & hit_rom;
      hsel_cti      = hsel & hit_cti;
      hsel_mtb_sfr  = hsel & hit_sfr;
      // Fixed regions win if the SRAM is moved on top of them
      hsel_mtb_sram = hsel & hit_sram & ~(hit_rom | hit_cti | hit_sfr);
   end

   // Selects advance only when the bus accepts an address phase
   always_ff @(posedge hclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         sel_rom_q <= 1'b0;
         sel_cti_q <= 1'b0;
         sel_mtb_q <= 1'b0;
      end
      else if (hready)
      begin
         sel_rom_q <= hsel_rom;
         sel_cti_q <= hsel_cti;
         // SFR and SRAM share one return path
         sel_mtb_q <= hsel_mtb_sfr | hsel_mtb_sram;
      end
   end

   // ------------------------------------------------------------
   // Response multiplexer
   // ------------------------------------------------------------
   assign sel_none = ~(sel_rom_q | sel_cti_q | sel_mtb_q);

   // Unmapped or idle: ready, OKAY, zero data
   assign hreadyout = (sel_rom_q & hreadyout_rom) |
                      (sel_cti_q & hreadyout_cti) |
                      (sel_mtb_q & hreadyout_mtb) |
                      sel_none;

   assign hresp = (sel_rom_q & hresp_rom) |
                  (sel_cti_q & hresp_cti) |
                  (sel_mtb_q & hresp_mtb);

   assign hrdata = ({ahb_pkg::DATA_W{sel_rom_q}} & hrdata_rom) |
                   ({ahb_pkg::DATA_W{sel_cti_q}} & hrdata_cti) |
                   ({ahb_pkg::DATA_W{sel_mtb_q}} & hrdata_mtb);

endmodule

`default_nettype wire

/* dbg_map_pkg.sv */
`default_nettype none

package dbg_map_pkg;

   // ------------------------------------------------------------
   // Fixed debug regions, 4 KB each
   // ------------------------------------------------------------
   localparam int REGION_LSB = 12;

   localparam ahb_pkg::addr_t ROM_TABLE_BASE = 32'hF000_0000;
   localparam ahb_pkg::addr_t CTI_BASE       = 32'hF000_1000;
   localparam ahb_pkg::addr_t MTB_SFR_BASE   = 32'hF000_2000;

   // Trace SRAM window, relocatable through the MTB BASE register
   localparam int             SRAM_AWIDTH     = 10;
   localparam ahb_pkg::addr_t SRAM_BASE_RESET = 32'h2000_0000;
   // Word index, byte lane bits dropped
   typedef logic [SRAM_AWIDTH-3:0] sram_idx_t;

   // Cross-trigger channels
   localparam int TRIG_W = 4;
   typedef logic [TRIG_W-1:0] trig_t;

   // ROM table words
   // Bit 0 marks the entry present, bit 1 the 32-bit format
   localparam ahb_pkg::data_t ROM_ENTRY0 = 32'h0000_1003;
   localparam ahb_pkg::data_t ROM_ENTRY1 = 32'h0000_2003;

   localparam logic [REGION_LSB-1:0] ROM_ENTRY0_OFS  = 12'h000;
   localparam logic [REGION_LSB-1:0] ROM_ENTRY1_OFS  = 12'h004;
   localparam logic [REGION_LSB-1:0] ROM_MEMTYPE_OFS = 12'hFCC;

   // CTI register offsets
   localparam logic [REGION_LSB-1:0] CTI_CONTROL_OFS  = 12'h000;
   localparam logic [REGION_LSB-1:0] CTI_APPSET_OFS   = 12'h014;
   localparam logic [REGION_LSB-1:0] CTI_APPCLEAR_OFS = 12'h018;
   localparam logic [REGION_LSB-1:0] CTI_TRIGOUT_OFS  = 12'h134;

   // MTB SFR offsets
   localparam logic [REGION_LSB-1:0] MTB_MASTER_OFS = 12'h004;
   localparam logic [REGION_LSB-1:0] MTB_BASE_OFS   = 12'h00C;

endpackage

`default_nettype wire

/* ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

   // Bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   // Single-bit HRESP as seen on AHB-Lite
   localparam logic HRESP_OKAY  = 1'b0;
   localparam logic HRESP_ERROR = 1'b1;

   // ------------------------------------------------------------
   // Slave response sequencer
   // ------------------------------------------------------------
   // WAIT stalls a read for one cycle
   // ERR1 drives ERROR with the bus held, ERR2 releases it
   typedef enum logic [1:0] {
      RESP_IDLE = 2'd0,
      RESP_WAIT = 2'd1,
      RESP_ERR1 = 2'd2,
      RESP_ERR2 = 2'd3
   } resp_state_t;

endpackage

`default_nettype wire
